//--- awg.f
src/awg_pkg.sv
src/awg_ctrl.sv
src/awg_dma_writer.sv
src/awg_sample_buffer.sv
src/awg_burst_player.sv
src/awg_top.sv
tests/awg_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the awg testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module awg_tb -f awg.f -o awg_sim; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/awg_sim)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" <<< "$sim_out"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- tests/awg_stim.txt
# depth bursts mode starts inject gaps expected_err, all decimal
# mode 0 none 1 each burst 2 first burst, inject 0 none 1 early last 2 missing last
7 1 0 1 0 0 0
15 3 1 1 0 1 0
3 4 2 1 0 0 0
0 5 1 1 0 0 0
255 2 1 1 0 1 0
9 2 1 0 1 0 1
9 2 1 1 0 0 0
12 1 0 0 2 1 2
12 2 2 1 0 1 0
31 2 1 3 0 1 0
5 0 1 3 0 0 0
4 1 0 0 0 0 0
6 2 2 1 0 0 0
1 3 1 0 1 0 1
1 3 1 1 0 0 0
20 3 2 3 0 1 0

//--- tests/awg_tb.sv
// waveform generator testbench
`timescale 1ns/1ps

module awg_tb;
  import awg_pkg::*;

  localparam int DEPTH = 256;
  localparam int AW = $clog2(DEPTH);
  localparam int MAX_REC = 64;

  logic                    dma_clk = 1'b0;
  logic                    reset_i;
  logic                    cfg_valid_i;
  logic [AW-1:0]           depth_i;
  logic [BURST_WIDTH-1:0]  bursts_i;
  trig_mode_e              trig_mode_i;
  logic [SAMPLE_WIDTH-1:0] dma_data_i;
  logic                    dma_valid_i;
  logic                    dma_last_i;
  logic                    start_i;
  logic                    stop_i;
  logic [SAMPLE_WIDTH-1:0] sample_o;
  logic                    sample_valid_o;
  logic                    trigger_o;
  xfer_err_e               xfer_err_o;
  logic                    xfer_err_valid_o;
  logic                    busy_o;

  // records: depth bursts mode starts inject gaps expected_err
  int rec [MAX_REC][7];
  int nrec = 0;
  // reference copy of the loaded waveform
  logic [SAMPLE_WIDTH-1:0] model [DEPTH];
  // captured playback, trigger positions are sample indices
  logic [SAMPLE_WIDTH-1:0] got_q [$];
  int trig_pos [$];
  int first_cyc;
  int xfer_pulses;
  int xfer_code;
  int cyc = 0;
  int errors = 0;
  int samples_checked = 0;
  int seed = 28;
  longint wd_limit_ns;
  logic wd_armed = 1'b0;

  awg_top #(.DEPTH(DEPTH)) awg_top_i (.*);

  always #4 dma_clk = ~dma_clk;

  // rising edge count, read at falling edges
  always @(posedge dma_clk) cyc <= cyc + 1;

  // outputs are registered, so the falling edge sees them settled
  always @(negedge dma_clk) begin
    if (!reset_i) begin
      if (sample_valid_o) begin
        if (got_q.size() == 0) first_cyc = cyc;
        if (trigger_o) trig_pos.push_back(got_q.size());
        got_q.push_back(sample_o);
      end else if (trigger_o) begin
        $display("trigger_o pulsed without sample_valid_o at cycle %0d", cyc);
        errors++;
      end
      if (xfer_err_valid_o) begin
        xfer_pulses++;
        xfer_code = int'(xfer_err_o);
      end
    end
  end

  task automatic report_mismatch(input string name, input longint gotv, input longint expv);
    $display("Mismatch %s got %h exp %h", name, gotv, expv);
    errors++;
  endtask

  task automatic wait_idle(input int limit, input string what);
    int n;
    n = 0;
    @(negedge dma_clk);
    while (busy_o && n < limit) begin
      @(negedge dma_clk);
      n++;
    end
    if (busy_o) begin
      $display("busy_o still high %0d cycles after %s in state %s",
               limit, what, awg_top_i.ctrl_state.name());
      errors++;
    end
  endtask

  task automatic configure(input int d, input int b, input int m);
    @(negedge dma_clk);
    cfg_valid_i = 1'b1;
    depth_i     = AW'(d);
    bursts_i    = BURST_WIDTH'(b);
    trig_mode_i = trig_mode_e'(m);
    @(negedge dma_clk);
    cfg_valid_i = 1'b0;
  endtask

  task automatic send_word(input logic [SAMPLE_WIDTH-1:0] data, input logic last,
                           input bit gap);
    // optional idle cycle in front of the word
    if (gap) begin
      @(negedge dma_clk);
      dma_valid_i = 1'b0;
      dma_last_i  = 1'b0;
    end
    @(negedge dma_clk);
    dma_valid_i = 1'b1;
    dma_data_i  = data;
    dma_last_i  = last;
  endtask

  task automatic load_stream(input int d, input int inj, input int gaps);
    int nwords;
    logic [SAMPLE_WIDTH-1:0] data;
    bit gap;
    // early last drops the final word
    nwords = (inj == 1) ? d : d + 1;
    for (int i = 0; i < nwords; i++) begin
      data = SAMPLE_WIDTH'($random(seed));
      gap  = (gaps != 0) && (($random(seed) & 1) != 0);
      if (inj == 0) model[i] = data;
      send_word(data, (i == nwords - 1) && (inj != 2), gap);
    end
    // overlong tail ends with its own last strobe
    if (inj == 2) begin
      send_word(16'h0bad, 1'b0, 1'b0);
      send_word(16'h0bad, 1'b1, 1'b0);
    end
    @(negedge dma_clk);
    dma_valid_i = 1'b0;
    dma_last_i  = 1'b0;
  endtask

  task automatic play_once(input int n, input int beff, input int m, input bit extra_start);
    int start_cyc;
    int exp_trig;
    got_q.delete();
    trig_pos.delete();
    @(negedge dma_clk);
    start_i   = 1'b1;
    start_cyc = cyc;
    @(negedge dma_clk);
    start_i = 1'b0;
    // a second start while playing must be ignored
    if (extra_start) begin
      @(negedge dma_clk);
      start_i = 1'b1;
      @(negedge dma_clk);
      start_i = 1'b0;
    end
    wait_idle(n * beff + 16, "start");
    @(negedge dma_clk);
    if (got_q.size() != n * beff) report_mismatch("sample_valid_o count", got_q.size(), n * beff);
    for (int i = 0; i < got_q.size(); i++) begin
      samples_checked++;
      if (got_q[i] !== model[i % n]) begin
        report_mismatch($sformatf("sample_o[%0d]", i), got_q[i], model[i % n]);
      end
    end
    if (got_q.size() != 0 && first_cyc - start_cyc != 2) begin
      report_mismatch("sample_valid_o latency", first_cyc - start_cyc, 2);
    end
    if (m == int'(TRIG_EACH_BURST)) exp_trig = beff;
    else if (m == int'(TRIG_FIRST_BURST)) exp_trig = 1;
    else exp_trig = 0;
    if (trig_pos.size() != exp_trig) report_mismatch("trigger_o count", trig_pos.size(), exp_trig);
    // each trigger opens a burst, so it sits on a multiple of n
    for (int k = 0; k < trig_pos.size(); k++) begin
      if (trig_pos[k] != k * n) begin
        report_mismatch($sformatf("trigger_o position %0d", k), trig_pos[k], k * n);
      end
    end
  endtask

  initial begin
    int fd;
    int d, b, m, r, inj, g, x;
    int beff;
    string line;
    reset_i     = 1'b1;
    cfg_valid_i = 1'b0;
    depth_i     = '0;
    bursts_i    = '0;
    trig_mode_i = TRIG_NONE;
    dma_data_i  = '0;
    dma_valid_i = 1'b0;
    dma_last_i  = 1'b0;
    start_i     = 1'b0;
    stop_i      = 1'b0;
    fd = $fopen("tests/awg_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/awg_stim.txt");
      errors++;
    end else begin
      while (!$feof(fd) && nrec < MAX_REC) begin
        line = "";
        // comment and blank lines match no field
        if ($fgets(line, fd) != 0 &&
            $sscanf(line, "%d %d %d %d %d %d %d", d, b, m, r, inj, g, x) == 7) begin
          rec[nrec] = '{d, b, m, r, inj, g, x};
          nrec++;
        end
      end
      $fclose(fd);
      if (nrec == 0) begin
        $display("no test records found in tests/awg_stim.txt");
        errors++;
      end
    end
    // watchdog budget from load and playback lengths
    wd_limit_ns = 4000;
    for (int i = 0; i < nrec; i++) begin
      beff = (rec[i][1] == 0) ? 1 : rec[i][1];
      wd_limit_ns += longint'(rec[i][0] + 1) * (beff * rec[i][3] + 2) * 8 + 64 * 8;
    end
    wd_armed = 1'b1;
    repeat (10) @(negedge dma_clk);
    reset_i = 1'b0;
    @(negedge dma_clk);
    if (busy_o !== 1'b0 || sample_valid_o !== 1'b0 || trigger_o !== 1'b0 ||
        xfer_err_valid_o !== 1'b0) begin
      $display("outputs not idle after reset");
      errors++;
    end
    for (int i = 0; i < nrec; i++) begin
      d    = rec[i][0];
      b    = rec[i][1];
      m    = rec[i][2];
      r    = rec[i][3];
      inj  = rec[i][4];
      g    = rec[i][5];
      x    = rec[i][6];
      beff = (b == 0) ? 1 : b;
      $display("record %0d depth %0d bursts %0d mode %0d starts %0d inject %0d gaps %0d",
               i, d, b, m, r, inj, g);
      xfer_pulses = 0;
      configure(d, b, m);
      load_stream(d, inj, g);
      wait_idle(16, "load");
      if (xfer_pulses != ((x != 0) ? 1 : 0)) begin
        report_mismatch("xfer_err_valid_o pulses", xfer_pulses, (x != 0) ? 1 : 0);
      end
      if (x != 0 && xfer_code != x) report_mismatch("xfer_err_o", xfer_code, x);
      // errored loads leave the controller idle, nothing to play
      if (x == 0) begin
        for (int k = 0; k < r; k++) play_once(d + 1, beff, m, k == 1);
      end
      // stop brings the controller back to idle for the next record
      got_q.delete();
      @(negedge dma_clk);
      stop_i = 1'b1;
      @(negedge dma_clk);
      stop_i = 1'b0;
      wait_idle(4, "stop");
      repeat (2) @(negedge dma_clk);
      if (got_q.size() != 0) report_mismatch("sample_valid_o after stop", got_q.size(), 0);
    end
    $display("records %0d samples checked %0d errors %0d", nrec, samples_checked, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    wait (wd_armed);
    #(wd_limit_ns);
    $display("watchdog expired after %0d ns, simulation stopped", wd_limit_ns);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- src/awg_top.sv
// arbitrary waveform generator top
`timescale 1ns/1ps

module awg_top #(
  parameter int DEPTH = 256
) (
  input  logic                               dma_clk,
  input  logic                               reset_i,
  // configuration
  input  logic                               cfg_valid_i,
  input  logic [$clog2(DEPTH)-1:0]           depth_i,
  input  logic [awg_pkg::BURST_WIDTH-1:0]    bursts_i,
  input  awg_pkg::trig_mode_e                trig_mode_i,
  // dma stream
  input  logic [awg_pkg::SAMPLE_WIDTH-1:0]   dma_data_i,
  input  logic                               dma_valid_i,
  input  logic                               dma_last_i,
  // commands
  input  logic                               start_i,
  input  logic                               stop_i,
  // waveform and status out
  output logic [awg_pkg::SAMPLE_WIDTH-1:0]   sample_o,
  output logic                               sample_valid_o,
  output logic                               trigger_o,
  output awg_pkg::xfer_err_e                 xfer_err_o,
  output logic                               xfer_err_valid_o,
  output logic                               busy_o
);
  import awg_pkg::*;

  localparam int AW = $clog2(DEPTH);

  // controller to datapath
  logic                    load_en;
  logic                    play_start;
  logic                    play_abort;
  logic [AW-1:0]           depth_q;
  logic [BURST_WIDTH-1:0]  bursts_q;
  trig_mode_e              mode_q;
  ctrl_state_e             ctrl_state;
  // datapath status
  logic                    load_done;
  logic                    xfer_err_valid;
  logic                    play_done;
  // buffer ports
  logic                    wr_en;
  logic [AW-1:0]           wr_addr;
  logic [SAMPLE_WIDTH-1:0] wr_data;
  logic                    rd_en;
  logic [AW-1:0]           rd_addr;
  logic [SAMPLE_WIDTH-1:0] rd_data;

  awg_ctrl #(
    .DEPTH(DEPTH)
  ) ctrl_i (
    .dma_clk          (dma_clk),
    .reset_i          (reset_i),
    .cfg_valid_i      (cfg_valid_i),
    .depth_i          (depth_i),
    .bursts_i         (bursts_i),
    .trig_mode_i      (trig_mode_i),
    .start_i          (start_i),
    .stop_i           (stop_i),
    .load_done_i      (load_done),
    .xfer_err_valid_i (xfer_err_valid),
    .play_done_i      (play_done),
    .load_en_o        (load_en),
    .play_start_o     (play_start),
    .play_abort_o     (play_abort),
    .depth_o          (depth_q),
    .bursts_o         (bursts_q),
    .mode_o           (mode_q),
    .state_o          (ctrl_state),
    .busy_o           (busy_o)
  );

  awg_dma_writer #(
    .DEPTH(DEPTH)
  ) writer_i (
    .dma_clk          (dma_clk),
    .reset_i          (reset_i),
    .load_en_i        (load_en),
    .depth_i          (depth_q),
    .dma_data_i       (dma_data_i),
    .dma_valid_i      (dma_valid_i),
    .dma_last_i       (dma_last_i),
    .wr_en_o          (wr_en),
    .wr_addr_o        (wr_addr),
    .wr_data_o        (wr_data),
    .load_done_o      (load_done),
    .xfer_err_o       (xfer_err_o),
    .xfer_err_valid_o (xfer_err_valid)
  );

  awg_sample_buffer #(
    .DEPTH(DEPTH)
  ) buffer_i (
    .dma_clk   (dma_clk),
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .rd_en_i   (rd_en),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  awg_burst_player #(
    .DEPTH(DEPTH)
  ) player_i (
    .dma_clk        (dma_clk),
    .reset_i        (reset_i),
    .play_start_i   (play_start),
    .play_abort_i   (play_abort),
    .depth_i        (depth_q),
    .bursts_i       (bursts_q),
    .mode_i         (mode_q),
    .rd_en_o        (rd_en),
    .rd_addr_o      (rd_addr),
    .rd_data_i      (rd_data),
    .sample_o       (sample_o),
    .sample_valid_o (sample_valid_o),
    .trigger_o      (trigger_o),
    .play_done_o    (play_done)
  );

  // error pulse leaves the chip as well as reaching the controller
  assign xfer_err_valid_o = xfer_err_valid;

endmodule

//--- src/awg_burst_player.sv
// burst playback sequencer
`timescale 1ns/1ps

module awg_burst_player #(
  parameter int DEPTH = 256
) (
  input  logic                               dma_clk,
  input  logic                               reset_i,
  input  logic                               play_start_i,
  input  logic                               play_abort_i,
  input  logic [$clog2(DEPTH)-1:0]           depth_i,
  input  logic [awg_pkg::BURST_WIDTH-1:0]    bursts_i,
  input  awg_pkg::trig_mode_e                mode_i,
  // buffer read port
  output logic                               rd_en_o,
  output logic [$clog2(DEPTH)-1:0]           rd_addr_o,
  input  logic [awg_pkg::SAMPLE_WIDTH-1:0]   rd_data_i,
  // waveform out
  output logic [awg_pkg::SAMPLE_WIDTH-1:0]   sample_o,
  output logic                               sample_valid_o,
  output logic                               trigger_o,
  output logic                               play_done_o
);
  import awg_pkg::*;

  localparam int AW = $clog2(DEPTH);

  logic                   run_q;
  logic [AW-1:0]          addr_q;
  logic [BURST_WIDTH-1:0] burst_cnt_q;
  logic [BURST_WIDTH-1:0] bursts_eff;
  logic                   last_addr;
  logic                   last_burst;
  logic                   trig_sel;
  logic                   valid_q;
  logic                   trig_q;
  logic                   done_q;

  // zero bursts plays once
  assign bursts_eff = (bursts_i == '0) ? BURST_WIDTH'(1) : bursts_i;
  assign last_addr  = (addr_q == depth_i);
  assign last_burst = (burst_cnt_q == bursts_eff - 1'b1);

  // first read goes out in the same cycle as the start pulse
  assign rd_en_o   = (play_start_i || run_q) && !play_abort_i;
  assign rd_addr_o = addr_q;

  // trigger decided at issue of the burst's first read
  always_comb begin
    case (mode_i)
      TRIG_EACH_BURST:  trig_sel = (addr_q == '0);
      TRIG_FIRST_BURST: trig_sel = (addr_q == '0) && (burst_cnt_q == '0);
      default:          trig_sel = 1'b0;
    endcase
  end

  // address and burst counters, addr_q rests at zero when idle
  always_ff @(posedge dma_clk) begin
    if (reset_i || play_abort_i) begin
      run_q       <= 1'b0;
      addr_q      <= '0;
      burst_cnt_q <= '0;
    end else if (rd_en_o) begin
      run_q <= 1'b1;
      if (last_addr) begin
        addr_q <= '0;
        if (last_burst) begin
          run_q       <= 1'b0;
          burst_cnt_q <= '0;
        end else begin
          burst_cnt_q <= burst_cnt_q + 1'b1;
        end
      end else begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  // valid and trigger delayed to meet the read data
  always_ff @(posedge dma_clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
      trig_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      valid_q <= rd_en_o;
      trig_q  <= rd_en_o && trig_sel;
      done_q  <= rd_en_o && last_addr && last_burst;
    end
  end

  assign sample_o       = rd_data_i;
  assign sample_valid_o = valid_q;
  assign trigger_o      = trig_q;
  assign play_done_o    = done_q;

endmodule

//--- src/awg_sample_buffer.sv
// waveform sample memory
`timescale 1ns/1ps

module awg_sample_buffer #(
  parameter int DEPTH = 256
) (
  input  logic                               dma_clk,
  // write side, from the dma writer
  input  logic                               wr_en_i,
  input  logic [$clog2(DEPTH)-1:0]           wr_addr_i,
  input  logic [awg_pkg::SAMPLE_WIDTH-1:0]   wr_data_i,
  // read side, from the player
  input  logic                               rd_en_i,
  input  logic [$clog2(DEPTH)-1:0]           rd_addr_i,
  output logic [awg_pkg::SAMPLE_WIDTH-1:0]   rd_data_o
);

  logic [awg_pkg::SAMPLE_WIDTH-1:0] mem [DEPTH];
  logic [awg_pkg::SAMPLE_WIDTH-1:0] rd_data_q;

  always_ff @(posedge dma_clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge dma_clk) begin
    if (rd_en_i) begin
      rd_data_q <= mem[rd_addr_i];
    end
  end

  assign rd_data_o = rd_data_q;

  // writer and player are never active at once
  a_no_rw_overlap: assert property (@(posedge dma_clk)
    !(wr_en_i && rd_en_i))
    else $error("buffer written and read in the same cycle");

endmodule

//--- src/awg_dma_writer.sv
// DMA sample stream writer
`timescale 1ns/1ps

module awg_dma_writer #(
  parameter int DEPTH = 256
) (
  input  logic                               dma_clk,
  input  logic                               reset_i,
  input  logic                               load_en_i,
  input  logic [$clog2(DEPTH)-1:0]           depth_i,
  // dma stream, never stalled
  input  logic [awg_pkg::SAMPLE_WIDTH-1:0]   dma_data_i,
  input  logic                               dma_valid_i,
  input  logic                               dma_last_i,
  // buffer write port
  output logic                               wr_en_o,
  output logic [$clog2(DEPTH)-1:0]           wr_addr_o,
  output logic [awg_pkg::SAMPLE_WIDTH-1:0]   wr_data_o,
  // status
  output logic                               load_done_o,
  output awg_pkg::xfer_err_e                 xfer_err_o,
  output logic                               xfer_err_valid_o
);
  import awg_pkg::*;

  localparam int AW = $clog2(DEPTH);

  logic [AW-1:0] cnt_q;
  logic          done_q;
  logic          discard_q;
  logic          accept;
  logic          at_depth;
  logic          load_done_q;
  logic          err_valid_q;
  xfer_err_e     err_q;

  // word taken only while loading and before the transfer ended
  assign accept   = dma_valid_i && load_en_i && !done_q && !discard_q;
  assign at_depth = (cnt_q == depth_i);

  always_ff @(posedge dma_clk) begin
    if (reset_i || !load_en_i) begin
      cnt_q       <= '0;
      done_q      <= 1'b0;
      discard_q   <= 1'b0;
      load_done_q <= 1'b0;
      err_valid_q <= 1'b0;
    end else begin
      load_done_q <= 1'b0;
      err_valid_q <= 1'b0;
      // overlong tail is dropped until its last strobe
      if (discard_q && dma_valid_i && dma_last_i) discard_q <= 1'b0;
      if (accept) begin
        if (dma_last_i) begin
          done_q <= 1'b1;
          if (at_depth) begin
            load_done_q <= 1'b1;
          end else begin
            err_valid_q <= 1'b1;
          end
        end else if (at_depth) begin
          // final word without last
          discard_q   <= 1'b1;
          err_valid_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  // error code, only meaningful with the valid pulse
  always_ff @(posedge dma_clk) begin
    if (accept && (dma_last_i || at_depth)) begin
      err_q <= dma_last_i ? XFER_EARLY_LAST : XFER_LATE_LAST;
    end
  end

  assign wr_en_o          = accept;
  assign wr_addr_o        = cnt_q;
  assign wr_data_o        = dma_data_i;
  assign load_done_o      = load_done_q;
  assign xfer_err_o       = err_q;
  assign xfer_err_valid_o = err_valid_q;

  // status pulses are exclusive and only follow a loading cycle
  a_done_err_excl: assert property (@(posedge dma_clk) disable iff (reset_i)
    (load_done_o || xfer_err_valid_o) |-> $past(load_en_i) && !(load_done_o && xfer_err_valid_o))
    else $error("load done and transfer error together");

endmodule

//--- src/awg_ctrl.sv
// waveform generator control FSM
`timescale 1ns/1ps

module awg_ctrl #(
  parameter int DEPTH = 256
) (
  input  logic                               dma_clk,
  input  logic                               reset_i,
  // configuration strobe and values
  input  logic                               cfg_valid_i,
  input  logic [$clog2(DEPTH)-1:0]           depth_i,
  input  logic [awg_pkg::BURST_WIDTH-1:0]    bursts_i,
  input  awg_pkg::trig_mode_e                trig_mode_i,
  // commands
  input  logic                               start_i,
  input  logic                               stop_i,
  // status from the datapath
  input  logic                               load_done_i,
  input  logic                               xfer_err_valid_i,
  input  logic                               play_done_i,
  // controls to the datapath
  output logic                               load_en_o,
  output logic                               play_start_o,
  output logic                               play_abort_o,
  output logic [$clog2(DEPTH)-1:0]           depth_o,
  output logic [awg_pkg::BURST_WIDTH-1:0]    bursts_o,
  output awg_pkg::trig_mode_e                mode_o,
  output awg_pkg::ctrl_state_e               state_o,
  output logic                               busy_o
);
  import awg_pkg::*;

  localparam int AW = $clog2(DEPTH);

  ctrl_state_e             state_q;
  logic [AW-1:0]           depth_q;
  logic [BURST_WIDTH-1:0]  bursts_q;
  trig_mode_e              mode_q;
  logic                    play_start_q;
  logic                    play_abort_q;

  // state register, stop overrides everything
  always_ff @(posedge dma_clk) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else if (stop_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (cfg_valid_i) state_q <= ST_LOAD;
        end
        ST_LOAD: begin
          // error takes priority, writer never raises both anyway
          if (xfer_err_valid_i) begin
            state_q <= ST_IDLE;
          end else if (load_done_i) begin
            state_q <= ST_READY;
          end
        end
        ST_READY: begin
          if (start_i) state_q <= ST_PLAY;
        end
        default: begin
          // start during play is dropped
          if (play_done_i) state_q <= ST_READY;
        end
      endcase
    end
  end

  // configuration only taken while idle
  always_ff @(posedge dma_clk) begin
    if (cfg_valid_i && state_q == ST_IDLE) begin
      depth_q  <= depth_i;
      bursts_q <= bursts_i;
      mode_q   <= trig_mode_i;
    end
  end

  // single-cycle pulses to the player
  always_ff @(posedge dma_clk) begin
    if (reset_i) begin
      play_start_q <= 1'b0;
      play_abort_q <= 1'b0;
    end else begin
      play_start_q <= start_i && !stop_i && state_q == ST_READY;
      play_abort_q <= stop_i;
    end
  end

  assign load_en_o    = (state_q == ST_LOAD);
  assign play_start_o = play_start_q;
  assign play_abort_o = play_abort_q;
  assign depth_o      = depth_q;
  assign bursts_o     = bursts_q;
  assign mode_o       = mode_q;
  assign state_o      = state_q;
  assign busy_o       = (state_q == ST_LOAD) || (state_q == ST_PLAY);

  // loading and playing never overlap
  a_load_not_play: assert property (@(posedge dma_clk) disable iff (reset_i)
    load_en_o |-> !play_done_i)
    else $error("load enable high during play");

  // a play start pulse always follows a ready state
  a_start_from_ready: assert property (@(posedge dma_clk) disable iff (reset_i)
    play_start_o |-> $past(state_q) == ST_READY && state_q == ST_PLAY)
    else $error("play start issued outside ready");

endmodule

//--- src/awg_pkg.sv
// waveform generator shared definitions
package awg_pkg;

  // one waveform sample per dma word
  localparam int SAMPLE_WIDTH = 16;

  // burst count configuration width
  localparam int BURST_WIDTH = 16;

  // trigger output behavior during playback
  typedef enum logic [1:0] {
    // no trigger at all
    TRIG_NONE        = 2'd0,
    // pulse at the first sample of every burst
    TRIG_EACH_BURST  = 2'd1,
    // pulse only at the first sample after start
    TRIG_FIRST_BURST = 2'd2
  } trig_mode_e;

  // transfer error code, 0 is never reported
  typedef enum logic [1:0] {
    XFER_EARLY_LAST = 2'd1,
    XFER_LATE_LAST  = 2'd2
  } xfer_err_e;

  // controller states
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_LOAD  = 2'd1,
    ST_READY = 2'd2,
    ST_PLAY  = 2'd3
  } ctrl_state_e;

endpackage
